// File: common/fdc_consts.svh
`ifndef FDC_CONSTS_SVH
`define FDC_CONSTS_SVH

// ==========================================================================
// drive limits and timing defaults
// ==========================================================================
`define FDC_NUM_DRIVES            2
`define FDC_MAX_CYL               80      // seek target must stay below this
`define FDC_DEFAULT_CYCLES_PER_MS 4000    // 4 MHz core clock
`define FDC_DEFAULT_SRT           4'd4    // step rate after reset

// ==========================================================================
// command bytes, upper three bits always zero
// ==========================================================================
`define FDC_OP_SPECIFY     8'h03
`define FDC_OP_SENSE_DRIVE 8'h04
`define FDC_OP_RECAL       8'h07
`define FDC_OP_SENSE_INT   8'h08
`define FDC_OP_SEEK        8'h0F

// main status register bit positions
// bits 1:0 are the per-drive seek busy flags
`define FDC_MSR_CB  4
`define FDC_MSR_DIO 6
`define FDC_MSR_RQM 7

// st0 result codes, drive number gets added to the first two
`define FDC_ST0_SEEK_END 8'h20
`define FDC_ST0_ABNORMAL 8'hE8
`define FDC_ST0_INVALID  8'h80

`endif

// File: common/fdc_pkg.sv
`default_nettype none

package fdc_pkg;

	// ======================================================================
	// bus and drive data types
	// ======================================================================
	typedef logic [7:0] byte_t;       // one host bus byte
	typedef logic [7:0] cyl_t;        // cylinder number
	typedef logic [3:0] step_rate_t;  // specify srt field, 0 means 16

	// ======================================================================
	// command fsm states
	// ======================================================================
	typedef enum logic [3:0] {
		ST_IDLE,        // waiting for a command byte
		// parameter phase
		ST_SPECIFY,     // srt / hut byte
		ST_SEEK_DRV,    // drive/head byte of seek
		ST_SEEK_CYL,    // new cylinder of seek
		ST_RECAL_DRV,   // drive byte of recalibrate
		ST_SDS_DRV,     // drive/head byte of sense drive status
		// result phase
		ST_SIS_ST0,     // sense interrupt status, st0
		ST_SIS_PCN,     // sense interrupt status, present cylinder
		ST_SDS_RES,     // sense drive status, st3
		ST_INVALID      // single 80h byte for unknown commands
	} cmd_state_e;

endpackage

`default_nettype wire

// File: source/fdc_host_port.sv
`timescale 1ns/10ps
`default_nettype none

module fdc_host_port (
	input  wire                 clk_sys,
	input  wire                 reset,
	input  wire                 i_n_rd,
	input  wire                 i_n_wr,
	input  wire                 i_a0,
	input  wire fdc_pkg::byte_t i_din,
	input  wire fdc_pkg::byte_t i_msr,
	input  wire fdc_pkg::byte_t i_rsp_data,
	output logic                o_wr_stb,
	output logic                o_rd_stb,
	output fdc_pkg::byte_t      o_wr_data,
	output fdc_pkg::byte_t      o_dout
);

	logic           rd_q, wr_q;        // sampled access state
	logic           rd_prev, wr_prev;  // access state one cycle back
	logic           a0_q;
	fdc_pkg::byte_t din_q;
	logic           rd_start;          // first cycle of any read
	logic           rd_a0;             // address of that read

	// ======================================================================
	// access detection
	// ======================================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rd_q     <= 1'b0;
			wr_q     <= 1'b0;
			rd_prev  <= 1'b0;
			wr_prev  <= 1'b0;
			rd_start <= 1'b0;
			o_wr_stb <= 1'b0;
		end else begin
			rd_q     <= ~i_n_rd;
			wr_q     <= ~i_n_wr;
			rd_prev  <= rd_q;
			wr_prev  <= wr_q;
			rd_start <= rd_q & ~rd_prev;
			o_wr_stb <= wr_q & ~wr_prev & a0_q;  // writes to msr are dropped
		end
	end

	assign o_rd_stb = rd_start & rd_a0;

	// address and data path
	always_ff @(posedge clk_sys) begin
		a0_q      <= i_a0;
		din_q     <= i_din;
		rd_a0     <= a0_q;
		o_wr_data <= din_q;
		if (rd_start) begin
			o_dout <= rd_a0 ? i_rsp_data : i_msr;
		end
	end

	a_strobe_excl: assert property (@(posedge clk_sys) disable iff (reset)
		!(o_rd_stb && o_wr_stb));

endmodule

`default_nettype wire

// File: source/fdc_seek_unit.sv
`timescale 1ns/10ps
`default_nettype none

`include "fdc_consts.svh"

module fdc_seek_unit #(
	parameter int P_STEP_CYCLES = `FDC_DEFAULT_CYCLES_PER_MS  // cycles per ms of srt
) (
	input  wire                      clk_sys,
	input  wire                      reset,
	input  wire                      i_seek_stb,
	input  wire fdc_pkg::cyl_t       i_seek_cyl,
	input  wire                      i_ready,
	input  wire fdc_pkg::step_rate_t i_step_rate,
	input  wire                      i_int_clear,
	input  wire                      i_int_ack,
	output logic                     o_busy,
	output logic                     o_int_pending,
	output logic                     o_int_ok,
	output fdc_pkg::cyl_t            o_pcn
);

	localparam int TMR_W = $clog2(P_STEP_CYCLES * 16 + 1);

	fdc_pkg::cyl_t    target;     // new cylinder number
	logic [TMR_W-1:0] step_tmr;
	logic [TMR_W-1:0] step_len;   // cycles per step
	logic [4:0]       srt_eff;
	logic             req_ok;

	assign srt_eff  = (i_step_rate == '0) ? 5'd16 : {1'b0, i_step_rate};
	assign step_len = TMR_W'(P_STEP_CYCLES * srt_eff);

	// cylinder 0 always reachable, anything else needs a ready drive
	assign req_ok = (i_seek_cyl == '0) || (i_ready && (i_seek_cyl < `FDC_MAX_CYL));

	always_ff @(posedge clk_sys) begin
		if (i_seek_stb && req_ok) begin
			target <= i_seek_cyl;
		end
	end

	// ======================================================================
	// step engine
	// ======================================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			o_busy        <= 1'b0;
			o_int_pending <= 1'b0;
			o_int_ok      <= 1'b0;
			o_pcn         <= '0;
			step_tmr      <= '0;
		end else begin
			if (i_int_clear || i_int_ack) begin
				o_int_pending <= 1'b0;
			end

			if (i_seek_stb) begin
				step_tmr <= '0;  // first step right away
				if (req_ok) begin
					o_busy        <= 1'b1;
					o_int_pending <= 1'b0;
				end else begin
					// seek error, no stepping
					o_busy        <= 1'b0;
					o_int_pending <= 1'b1;
					o_int_ok      <= 1'b0;
				end
			end else if (o_busy) begin
				if (step_tmr != '0) begin
					step_tmr <= step_tmr - TMR_W'(1);
				end else if (o_pcn == target) begin
					o_busy        <= 1'b0;
					o_int_pending <= 1'b1;
					o_int_ok      <= i_ready;  // recal of an empty drive ends abnormal
				end else begin
					o_pcn    <= (o_pcn < target) ? o_pcn + 8'd1 : o_pcn - 8'd1;
					step_tmr <= step_len - TMR_W'(1);
				end
			end
		end
	end

	a_pcn_range: assert property (@(posedge clk_sys) disable iff (reset)
		o_pcn < `FDC_MAX_CYL);

	// completion hands over from busy to the interrupt flag in one edge
	a_busy_int_excl: assert property (@(posedge clk_sys) disable iff (reset)
		!(o_busy && o_int_pending));

endmodule

`default_nettype wire

// File: fdc_cmd/fdc_cmd_fsm.sv
`timescale 1ns/10ps
`default_nettype none

`include "fdc_consts.svh"

module fdc_cmd_fsm (
	input  wire                        clk_sys,
	input  wire                        reset,
	input  wire                        i_wr_stb,
	input  wire                        i_rd_stb,
	input  wire fdc_pkg::byte_t        i_wr_data,
	output fdc_pkg::byte_t             o_rsp_data,
	output fdc_pkg::byte_t             o_msr,
	input  wire [`FDC_NUM_DRIVES-1:0]  i_ready,
	input  wire [`FDC_NUM_DRIVES-1:0]  i_wp,
	input  wire [`FDC_NUM_DRIVES-1:0]  i_busy,
	input  wire [`FDC_NUM_DRIVES-1:0]  i_int_pending,
	input  wire [`FDC_NUM_DRIVES-1:0]  i_int_ok,
	input  wire fdc_pkg::cyl_t         i_pcn0,
	input  wire fdc_pkg::cyl_t         i_pcn1,
	output logic [`FDC_NUM_DRIVES-1:0] o_seek_stb,
	output fdc_pkg::cyl_t              o_seek_cyl,
	output logic                       o_int_clear,
	output logic [`FDC_NUM_DRIVES-1:0] o_int_ack,
	output fdc_pkg::step_rate_t        o_step_rate
);

	fdc_pkg::cmd_state_e state;
	logic                drv;       // us0 of the last drive/head byte
	logic                head;      // hd of the last drive/head byte
	logic                sis_drv;   // drive reported by sense int status
	logic                any_int;
	logic                int_drv;   // lowest drive with an interrupt
	logic                in_result;
	fdc_pkg::cyl_t       drv_pcn;
	fdc_pkg::cyl_t       sis_pcn;

	assign any_int = |i_int_pending;
	assign int_drv = ~i_int_pending[0];  // drive 0 wins
	assign drv_pcn = drv ? i_pcn1 : i_pcn0;
	assign sis_pcn = sis_drv ? i_pcn1 : i_pcn0;

	assign in_result = (state == fdc_pkg::ST_SIS_ST0) || (state == fdc_pkg::ST_SIS_PCN) ||
		(state == fdc_pkg::ST_SDS_RES) || (state == fdc_pkg::ST_INVALID);

	// ======================================================================
	// command sequencing
	// ======================================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state       <= fdc_pkg::ST_IDLE;
			o_step_rate <= `FDC_DEFAULT_SRT;
			drv         <= 1'b0;
			head        <= 1'b0;
			sis_drv     <= 1'b0;
		end else begin
			case (state)
				fdc_pkg::ST_IDLE: begin
					if (i_wr_stb) begin
						case (i_wr_data)
							`FDC_OP_SPECIFY:     state <= fdc_pkg::ST_SPECIFY;
							`FDC_OP_SENSE_DRIVE: state <= fdc_pkg::ST_SDS_DRV;
							`FDC_OP_RECAL:       state <= fdc_pkg::ST_RECAL_DRV;
							`FDC_OP_SENSE_INT:   state <= fdc_pkg::ST_SIS_ST0;
							`FDC_OP_SEEK:        state <= fdc_pkg::ST_SEEK_DRV;
							default:             state <= fdc_pkg::ST_INVALID;
						endcase
					end
				end

				fdc_pkg::ST_SPECIFY: begin
					if (i_wr_stb) begin
						o_step_rate <= i_wr_data[7:4];  // hut in the low nibble is ignored
						state       <= fdc_pkg::ST_IDLE;
					end
				end

				fdc_pkg::ST_SEEK_DRV: begin
					if (i_wr_stb) begin
						drv   <= i_wr_data[0];
						state <= fdc_pkg::ST_SEEK_CYL;
					end
				end

				fdc_pkg::ST_SEEK_CYL: begin
					if (i_wr_stb) begin
						state <= fdc_pkg::ST_IDLE;  // seek unit takes over
					end
				end

				fdc_pkg::ST_RECAL_DRV: begin
					if (i_wr_stb) begin
						state <= fdc_pkg::ST_IDLE;
					end
				end

				fdc_pkg::ST_SDS_DRV: begin
					if (i_wr_stb) begin
						drv   <= i_wr_data[0];
						head  <= i_wr_data[2];
						state <= fdc_pkg::ST_SDS_RES;
					end
				end

				fdc_pkg::ST_SIS_ST0: begin
					if (i_rd_stb) begin
						if (any_int) begin
							sis_drv <= int_drv;
							state   <= fdc_pkg::ST_SIS_PCN;
						end else begin
							state <= fdc_pkg::ST_IDLE;  // lone 80h byte
						end
					end
				end

				fdc_pkg::ST_SIS_PCN, fdc_pkg::ST_SDS_RES, fdc_pkg::ST_INVALID: begin
					if (i_rd_stb) begin
						state <= fdc_pkg::ST_IDLE;
					end
				end

				default: state <= fdc_pkg::ST_IDLE;
			endcase
		end
	end

	// ======================================================================
	// seek unit control
	// ======================================================================
	always_comb begin
		o_seek_stb  = '0;
		o_seek_cyl  = '0;  // recalibrate heads for cylinder 0
		o_int_ack   = '0;
		o_int_clear = 1'b0;
		if (i_wr_stb && state == fdc_pkg::ST_SEEK_CYL) begin
			o_seek_stb[drv] = 1'b1;
			o_seek_cyl      = i_wr_data;
		end
		if (i_wr_stb && state == fdc_pkg::ST_RECAL_DRV) begin
			o_seek_stb[i_wr_data[0]] = 1'b1;
		end
		if (i_rd_stb && state == fdc_pkg::ST_SIS_PCN) begin
			o_int_ack[sis_drv] = 1'b1;
		end
		if (i_wr_stb && state == fdc_pkg::ST_IDLE &&
				(i_wr_data == `FDC_OP_SPECIFY || i_wr_data == `FDC_OP_SENSE_DRIVE)) begin
			o_int_clear = 1'b1;
		end
	end

	// result byte for the current state
	always_comb begin
		case (state)
			fdc_pkg::ST_SIS_ST0: begin
				if (any_int) begin
					o_rsp_data = (i_int_ok[int_drv] ? `FDC_ST0_SEEK_END : `FDC_ST0_ABNORMAL) +
						{7'd0, int_drv};
				end else begin
					o_rsp_data = `FDC_ST0_INVALID;
				end
			end
			fdc_pkg::ST_SIS_PCN: o_rsp_data = sis_pcn;
			fdc_pkg::ST_SDS_RES: o_rsp_data = {1'b0,
				i_wp[drv] & i_ready[drv],  // write protected
				i_ready[drv],
				drv_pcn == '0,             // track 0
				1'b0,                      // single sided
				head,
				1'b0,
				drv};
			fdc_pkg::ST_INVALID: o_rsp_data = `FDC_ST0_INVALID;
			default:             o_rsp_data = 8'hFF;  // no result pending
		endcase
	end

	// main status register
	always_comb begin
		o_msr               = '0;
		o_msr[1:0]          = i_busy;
		o_msr[`FDC_MSR_CB]  = (state != fdc_pkg::ST_IDLE);
		o_msr[`FDC_MSR_DIO] = in_result;
		o_msr[`FDC_MSR_RQM] = !((state == fdc_pkg::ST_IDLE) && (|i_busy));
	end

endmodule

`default_nettype wire

// File: source/fdc_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "fdc_consts.svh"

module fdc_top #(
	parameter int P_CYCLES_PER_MS = `FDC_DEFAULT_CYCLES_PER_MS  // clock cycles per ms
) (
	input  wire                         clk_sys,
	input  wire                         reset,
	input  wire                         i_n_rd,
	input  wire                         i_n_wr,
	input  wire                         i_a0,
	input  wire fdc_pkg::byte_t         i_din,
	output fdc_pkg::byte_t              o_dout,
	input  wire [`FDC_NUM_DRIVES-1:0]   i_ready,
	input  wire [`FDC_NUM_DRIVES-1:0]   i_wp
);

	// host port <-> command fsm
	logic                       wr_stb;
	logic                       rd_stb;
	fdc_pkg::byte_t             wr_data;
	fdc_pkg::byte_t             rsp_data;
	fdc_pkg::byte_t             msr;

	// command fsm <-> seek units
	logic [`FDC_NUM_DRIVES-1:0] seek_stb;
	fdc_pkg::cyl_t              seek_cyl;
	logic                       int_clear;
	logic [`FDC_NUM_DRIVES-1:0] int_ack;
	fdc_pkg::step_rate_t        step_rate;
	logic [`FDC_NUM_DRIVES-1:0] busy;
	logic [`FDC_NUM_DRIVES-1:0] int_pending;
	logic [`FDC_NUM_DRIVES-1:0] int_ok;
	fdc_pkg::cyl_t              pcn0;
	fdc_pkg::cyl_t              pcn1;

	fdc_host_port u_host_port (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.i_n_rd       (i_n_rd),
		.i_n_wr       (i_n_wr),
		.i_a0         (i_a0),
		.i_din        (i_din),
		.i_msr        (msr),
		.i_rsp_data   (rsp_data),
		.o_wr_stb     (wr_stb),
		.o_rd_stb     (rd_stb),
		.o_wr_data    (wr_data),
		.o_dout       (o_dout)
	);

	fdc_cmd_fsm u_cmd_fsm (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.i_wr_stb      (wr_stb),
		.i_rd_stb      (rd_stb),
		.i_wr_data     (wr_data),
		.o_rsp_data    (rsp_data),
		.o_msr         (msr),
		.i_ready       (i_ready),
		.i_wp          (i_wp),
		.i_busy        (busy),
		.i_int_pending (int_pending),
		.i_int_ok      (int_ok),
		.i_pcn0        (pcn0),
		.i_pcn1        (pcn1),
		.o_seek_stb    (seek_stb),
		.o_seek_cyl    (seek_cyl),
		.o_int_clear   (int_clear),
		.o_int_ack     (int_ack),
		.o_step_rate   (step_rate)
	);

	// one seek unit per drive, both run at the same time
	fdc_seek_unit #(.P_STEP_CYCLES(P_CYCLES_PER_MS)) u_seek0 (
		.clk_sys(clk_sys), .reset(reset),
		.i_seek_stb(seek_stb[0]), .i_seek_cyl(seek_cyl), .i_ready(i_ready[0]),
		.i_step_rate(step_rate), .i_int_clear(int_clear), .i_int_ack(int_ack[0]),
		.o_busy(busy[0]), .o_int_pending(int_pending[0]), .o_int_ok(int_ok[0]),
		.o_pcn(pcn0)
	);

	fdc_seek_unit #(.P_STEP_CYCLES(P_CYCLES_PER_MS)) u_seek1 (
		.clk_sys(clk_sys), .reset(reset),
		.i_seek_stb(seek_stb[1]), .i_seek_cyl(seek_cyl), .i_ready(i_ready[1]),
		.i_step_rate(step_rate), .i_int_clear(int_clear), .i_int_ack(int_ack[1]),
		.o_busy(busy[1]), .o_int_pending(int_pending[1]), .o_int_ok(int_ok[1]),
		.o_pcn(pcn1)
	);

endmodule

`default_nettype wire

// File: tb/tb_fdc.sv
`timescale 1ns/10ps
`default_nettype none

`include "fdc_consts.svh"

module tb_fdc;

	localparam int CLK_PERIOD   = 10;
	localparam int CYC_PER_MS   = 8;
	localparam int STEP_CYC     = CYC_PER_MS * 2;   // srt of 2
	localparam int MAX_DIST     = 20;               // largest random target
	localparam int ACCESS_CYC   = 9;                // one bus access incl. idle
	localparam int MAX_ACCESS   = 64;
	localparam int MAX_POLLS    = (MAX_DIST + 2) * STEP_CYC / ACCESS_CYC + 2;
	localparam int WATCHDOG_CYC = 8 + 2 * (MAX_DIST + 1) * STEP_CYC +
		MAX_ACCESS * ACCESS_CYC + 500;
	localparam logic A_STATUS   = 1'b0;
	localparam logic A_DATA     = 1'b1;

	logic                       clk_sys = 1'b0;
	logic                       reset;
	logic                       i_n_rd;
	logic                       i_n_wr;
	logic                       i_a0;
	fdc_pkg::byte_t             i_din;
	fdc_pkg::byte_t             o_dout;
	logic [`FDC_NUM_DRIVES-1:0] i_ready;
	logic [`FDC_NUM_DRIVES-1:0] i_wp;

	logic [31:0]   lfsr_state;
	fdc_pkg::cyl_t pcn_exp [`FDC_NUM_DRIVES];  // head position model
	int            errors;
	int            err_mark;
	int            tests_run;
	int            tests_failed;
	string         test_name;

	fdc_top #(.P_CYCLES_PER_MS(CYC_PER_MS)) i_dut (
		.clk_sys (clk_sys),
		.reset   (reset),
		.i_n_rd  (i_n_rd),
		.i_n_wr  (i_n_wr),
		.i_a0    (i_a0),
		.i_din   (i_din),
		.o_dout  (o_dout),
		.i_ready (i_ready),
		.i_wp    (i_wp)
	);

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	// o_dout only moves while a read pulse is low
	a_dout_on_read: assert property (@(posedge clk_sys) disable iff (reset || $isunknown(o_dout))
		!$stable(o_dout) |-> !i_n_rd)
		else begin
			$display("o_dout changed at %0t ns with no read in progress", $time);
			errors++;
		end

	initial begin
		#(WATCHDOG_CYC * CLK_PERIOD);
		$display("watchdog expired after %0d cycles, a test hung", WATCHDOG_CYC);
		$display(">>> FAIL");
		$finish;
	end

	// ======================================================================
	// expected values and random numbers
	// ======================================================================
	function automatic fdc_pkg::byte_t msr_value(input logic rqm, input logic dio,
			input logic cb, input logic [1:0] busy);
		return {rqm, dio, 1'b0, cb, 2'b00, busy};
	endfunction

	function automatic fdc_pkg::byte_t st0_value(input logic ok, input logic drv);
		return (ok ? `FDC_ST0_SEEK_END : `FDC_ST0_ABNORMAL) | {7'd0, drv};
	endfunction

	function automatic fdc_pkg::byte_t st3_value(input logic wp, input logic rdy,
			input logic trk0, input logic head, input logic drv);
		return {1'b0, wp & rdy, rdy, trk0, 1'b0, head, 1'b0, drv};
	endfunction

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output logic [7:0] bits);
		bits = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			bits       = {bits[6:0], lfsr_state[0]};
		end
	endtask

	// ======================================================================
	// host bus access
	// ======================================================================
	task automatic bus_write(input logic a0, input fdc_pkg::byte_t data);
		@(posedge clk_sys);
		i_a0   <= a0;
		i_din  <= data;
		i_n_wr <= 1'b0;
		repeat (4) @(posedge clk_sys);
		i_n_wr <= 1'b1;
		repeat (4) @(posedge clk_sys);
	endtask

	task automatic bus_read(input logic a0, output fdc_pkg::byte_t data);
		@(posedge clk_sys);
		i_a0   <= a0;
		i_n_rd <= 1'b0;
		repeat (4) @(posedge clk_sys);
		i_n_rd <= 1'b1;
		repeat (4) @(posedge clk_sys);
		data = o_dout;  // latched long before, stable here
	endtask

	task automatic check_byte(input string what, input fdc_pkg::byte_t exp,
			input fdc_pkg::byte_t got);
		assert (got === exp) else begin
			$display("FAIL %0t ns o_dout (%s) expected %02h got %02h", $time, what, exp, got);
			errors++;
		end
	endtask

	task automatic seek(input logic drv, input fdc_pkg::cyl_t cyl);
		bus_write(A_DATA, `FDC_OP_SEEK);
		bus_write(A_DATA, {7'd0, drv});
		bus_write(A_DATA, cyl);
	endtask

	// poll the status register until the drive's busy bit drops
	task automatic wait_seek_done(input int drv);
		fdc_pkg::byte_t msr;
		int             polls;
		polls = 0;
		bus_read(A_STATUS, msr);
		while (msr[drv] && polls < MAX_POLLS) begin
			bus_read(A_STATUS, msr);
			polls++;
		end
		if (msr[drv]) begin
			$display("drive %0d still busy after %0d status polls", drv, polls);
			errors++;
		end
		check_byte("status after seek", msr_value(1'b1, 1'b0, 1'b0, 2'b00), msr);
	endtask

	task automatic sense_int(input fdc_pkg::byte_t exp_st0, input fdc_pkg::cyl_t exp_pcn);
		fdc_pkg::byte_t got;
		bus_write(A_DATA, `FDC_OP_SENSE_INT);
		bus_read(A_DATA, got);
		check_byte("sis st0", exp_st0, got);
		if (exp_st0 != `FDC_ST0_INVALID) begin
			bus_read(A_DATA, got);
			check_byte("sis pcn", exp_pcn, got);
		end
	endtask

	task automatic start_test(input string name);
		test_name = name;
		err_mark  = errors;
		tests_run++;
	endtask

	task automatic finish_test();
		if (errors == err_mark) begin
			$display("test %0d %s: ok", tests_run, test_name);
		end else begin
			tests_failed++;
			$display("test %0d %s: failed, %0d errors", tests_run, test_name, errors - err_mark);
		end
	endtask

	// ======================================================================
	// stimulus
	// ======================================================================
	initial begin
		fdc_pkg::byte_t got;
		fdc_pkg::cyl_t  target;
		logic [7:0]     raw;
		reset   <= 1'b1;
		i_n_rd  <= 1'b1;
		i_n_wr  <= 1'b1;
		i_a0    <= 1'b0;
		i_din   <= '0;
		i_ready <= '1;
		i_wp    <= '0;
		lfsr_state   = 32'h29cb3dac;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		pcn_exp[0]   = '0;
		pcn_exp[1]   = '0;
		repeat (8) @(posedge clk_sys);
		reset <= 1'b0;
		repeat (2) @(posedge clk_sys);

		start_test("status after reset");
		bus_read(A_STATUS, got);
		check_byte("msr", msr_value(1'b1, 1'b0, 1'b0, 2'b00), got);
		finish_test();

		start_test("seek drive 0");
		take_bits(5, raw);
		target = (raw % 8'd20) + 8'd1;
		bus_write(A_DATA, `FDC_OP_SPECIFY);
		bus_write(A_DATA, {4'd2, 4'hF});
		seek(1'b0, target);
		bus_read(A_STATUS, got);  // still stepping
		check_byte("msr busy", msr_value(1'b0, 1'b0, 1'b0, 2'b01), got);
		wait_seek_done(0);
		pcn_exp[0] = target;
		sense_int(st0_value(1'b1, 1'b0), pcn_exp[0]);
		sense_int(`FDC_ST0_INVALID, '0);  // nothing left pending
		finish_test();

		start_test("seek errors drive 1");
		i_ready[1] <= 1'b0;
		seek(1'b1, target);
		sense_int(st0_value(1'b0, 1'b1), pcn_exp[1]);
		i_ready[1] <= 1'b1;
		seek(1'b1, 8'd90);  // past the last cylinder
		sense_int(st0_value(1'b0, 1'b1), pcn_exp[1]);
		finish_test();

		start_test("recalibrate drive 0");
		bus_write(A_DATA, `FDC_OP_RECAL);
		bus_write(A_DATA, 8'h00);
		wait_seek_done(0);
		pcn_exp[0] = '0;
		sense_int(st0_value(1'b1, 1'b0), pcn_exp[0]);
		finish_test();

		start_test("sense drive status");
		i_wp[0] <= 1'b1;
		bus_write(A_DATA, `FDC_OP_SENSE_DRIVE);
		bus_write(A_DATA, 8'h04);  // head 1, drive 0
		bus_read(A_STATUS, got);
		check_byte("msr result", msr_value(1'b1, 1'b1, 1'b1, 2'b00), got);
		bus_read(A_DATA, got);
		check_byte("st3 wp", st3_value(1'b1, 1'b1, pcn_exp[0] == '0, 1'b1, 1'b0), got);
		i_wp[0] <= 1'b0;
		bus_write(A_DATA, `FDC_OP_SENSE_DRIVE);
		bus_write(A_DATA, 8'h04);
		bus_read(A_DATA, got);
		check_byte("st3", st3_value(1'b0, 1'b1, pcn_exp[0] == '0, 1'b1, 1'b0), got);
		finish_test();

		start_test("invalid command");
		bus_write(A_DATA, 8'h06);  // read data, not supported
		bus_read(A_DATA, got);
		check_byte("invalid st0", `FDC_ST0_INVALID, got);
		bus_read(A_STATUS, got);
		check_byte("msr", msr_value(1'b1, 1'b0, 1'b0, 2'b00), got);
		finish_test();

		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: project.f
+incdir+common
common/fdc_pkg.sv
source/fdc_host_port.sv
source/fdc_seek_unit.sv
fdc_cmd/fdc_cmd_fsm.sv
source/fdc_top.sv
tb/tb_fdc.sv

// File: Makefile
# Verilator build and run for the floppy controller command core

VERILATOR ?= verilator
TOP       ?= tb_fdc
LOG       ?= sim.log
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) common/fdc_consts.svh
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) | tee $(LOG)
	@grep -q '^>>> PASS$$' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
